// ==== rtl/alu_pipe.sv ====
/* single-cycle ALU with a registered result
   slt compares unsigned and yields 1 or 0 */
module alu_pipe
	import core_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       i_valid,
	input  logic [1:0] i_op,
	input  data_t      i_op_a,
	input  data_t      i_op_b,
	input  reg_addr_t  i_dest,
	output logic       o_valid,
	output data_t      o_result,
	output reg_addr_t  o_dest
);
	data_t alu_out;

	always_comb
	begin
		case (i_op)
			ALU_ADD: alu_out = i_op_a + i_op_b;
			ALU_SUB: alu_out = i_op_a - i_op_b;
			ALU_AND: alu_out = i_op_a & i_op_b;
			default: alu_out = (i_op_a < i_op_b) ? data_t'(1) : data_t'(0);    // slt
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		o_result <= alu_out;
		o_dest   <= i_dest;
	end

endmodule

// ==== rtl/core_pkg.sv ====
/* shared widths, encodings and instruction views of the execution core
   R-type funct sits in the low six bits, addi takes a zero-extended immediate */
package core_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	// opcodes
	localparam logic [5:0] OP_RTYPE = 6'd1;
	localparam logic [5:0] OP_ADDI  = 6'd5;

	// R-type functs, one-hot encoded
	localparam logic [5:0] FN_ADD = 6'd1;
	localparam logic [5:0] FN_SUB = 6'd2;
	localparam logic [5:0] FN_AND = 6'd4;
	localparam logic [5:0] FN_MUL = 6'd8;
	localparam logic [5:0] FN_SLT = 6'd16;

	// ALU operation codes
	localparam logic [1:0] ALU_ADD = 2'd0;
	localparam logic [1:0] ALU_SUB = 2'd1;
	localparam logic [1:0] ALU_AND = 2'd2;
	localparam logic [1:0] ALU_SLT = 2'd3;

	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] pad;    // ignored
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;       // destination of addi
		logic [15:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

endpackage

// ==== rtl/exec_core.sv ====
/* back end of the in-order core: issue, ALU and multiply pipes, writeback
   results appear 2 edges after acceptance for ALU ops and MUL_STAGES+1 for multiplies */
module exec_core
	import core_pkg::*;
#(
	parameter int MUL_STAGES = 4
)
(
	input  logic      clk,
	input  logic      rst,
	input  instr_u    i_inst,
	input  logic      i_inst_valid,
	output logic      o_stall,
	output logic      o_wb_en,
	output reg_addr_t o_wb_addr,
	output data_t     o_wb_data
);
	logic       alu_valid;
	logic [1:0] alu_op;
	logic       mul_valid;
	data_t      op_a;
	data_t      op_b;
	reg_addr_t  dest;
	logic       alu_res_valid;
	data_t      alu_result;
	reg_addr_t  alu_dest;
	logic       mul_res_valid;
	data_t      mul_result;
	reg_addr_t  mul_dest;

	issue_stage #(.MUL_STAGES(MUL_STAGES)) u_issue (
		.clk          (clk),
		.rst          (rst),
		.i_inst       (i_inst),
		.i_inst_valid (i_inst_valid),
		.i_wb_en      (o_wb_en),       // write port loops back to the register file
		.i_wb_addr    (o_wb_addr),
		.i_wb_data    (o_wb_data),
		.o_stall      (o_stall),
		.o_alu_valid  (alu_valid),
		.o_alu_op     (alu_op),
		.o_mul_valid  (mul_valid),
		.o_op_a       (op_a),
		.o_op_b       (op_b),
		.o_dest       (dest)
	);

	alu_pipe u_alu (
		.clk      (clk),
		.rst      (rst),
		.i_valid  (alu_valid),
		.i_op     (alu_op),
		.i_op_a   (op_a),
		.i_op_b   (op_b),
		.i_dest   (dest),
		.o_valid  (alu_res_valid),
		.o_result (alu_result),
		.o_dest   (alu_dest)
	);

	mul_pipe #(.MUL_STAGES(MUL_STAGES)) u_mul (
		.clk      (clk),
		.rst      (rst),
		.i_valid  (mul_valid),
		.i_op_a   (op_a),
		.i_op_b   (op_b),
		.i_dest   (dest),
		.o_valid  (mul_res_valid),
		.o_result (mul_result),
		.o_dest   (mul_dest)
	);

	writeback u_wb (
		.clk          (clk),
		.rst          (rst),
		.i_alu_valid  (alu_res_valid),
		.i_alu_result (alu_result),
		.i_alu_dest   (alu_dest),
		.i_mul_valid  (mul_res_valid),
		.i_mul_result (mul_result),
		.i_mul_dest   (mul_dest),
		.o_wb_en      (o_wb_en),
		.o_wb_addr    (o_wb_addr),
		.o_wb_data    (o_wb_data)
	);

endmodule

// ==== rtl/issue_stage.sv ====
/* MUL_STAGES must be 2 or more; unknown opcodes and functs issue nothing
   the source must hold the instruction for as long as o_stall is high */
module issue_stage
	import core_pkg::*;
#(
	parameter int MUL_STAGES = 4
)
(
	input  logic       clk,
	input  logic       rst,
	input  instr_u     i_inst,
	input  logic       i_inst_valid,
	input  logic       i_wb_en,
	input  reg_addr_t  i_wb_addr,
	input  data_t      i_wb_data,
	output logic       o_stall,
	output logic       o_alu_valid,
	output logic [1:0] o_alu_op,
	output logic       o_mul_valid,
	output data_t      o_op_a,
	output data_t      o_op_b,
	output reg_addr_t  o_dest
);
	logic                  dec_alu;
	logic                  dec_mul;
	logic                  dec_imm;
	logic [1:0]            dec_op;
	reg_addr_t             dec_dest;
	data_t                 rd_data_a;
	data_t                 rd_data_b;
	logic                  accept;
	logic [MUL_STAGES-2:0] mul_hist;    // bit i set i+1 cycles after a mul issued

	always_comb
	begin
		dec_alu  = 1'b0;
		dec_mul  = 1'b0;
		dec_imm  = 1'b0;
		dec_op   = ALU_ADD;
		dec_dest = i_inst.r.rd;
		case (i_inst.r.opcode)
			OP_RTYPE:
			begin
				dec_alu = 1'b1;
				case (i_inst.r.funct)
					FN_ADD: dec_op = ALU_ADD;
					FN_SUB: dec_op = ALU_SUB;
					FN_AND: dec_op = ALU_AND;
					FN_SLT: dec_op = ALU_SLT;
					FN_MUL:
					begin
						dec_alu = 1'b0;
						dec_mul = 1'b1;
					end
					default: dec_alu = 1'b0;    // nop
				endcase
			end
			OP_ADDI:
			begin
				dec_alu  = 1'b1;
				dec_imm  = 1'b1;
				dec_dest = i_inst.i.rt;
			end
			default: dec_alu = 1'b0;
		endcase
	end

	register_file u_regs (
		.clk         (clk),
		.rst         (rst),
		.i_rd_addr_a (i_inst.r.rs),
		.i_rd_addr_b (i_inst.r.rt),
		.o_rd_data_a (rd_data_a),
		.o_rd_data_b (rd_data_b),
		.i_wr_en     (i_wb_en),
		.i_wr_addr   (i_wb_addr),
		.i_wr_data   (i_wb_data)
	);

	// ALU result would reach writeback together with that multiply
	assign o_stall = i_inst_valid & dec_alu & mul_hist[MUL_STAGES-2];
	assign accept  = i_inst_valid & ~o_stall;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			mul_hist    <= '0;
			o_alu_valid <= 1'b0;
			o_mul_valid <= 1'b0;
		end
		else
		begin
			mul_hist[0] <= accept & dec_mul;
			for (int i = 1; i < MUL_STAGES - 1; i++)
				mul_hist[i] <= mul_hist[i-1];
			o_alu_valid <= accept & dec_alu;
			o_mul_valid <= accept & dec_mul;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			o_alu_op <= dec_op;
			o_op_a   <= rd_data_a;
			o_op_b   <= dec_imm ? {{(DATA_W-16){1'b0}}, i_inst.i.imm} : rd_data_b;
			o_dest   <= dec_dest;
		end
	end

	a_one_pipe: assert property (@(posedge clk) disable iff (!rst)
		!(o_alu_valid && o_mul_valid));

endmodule

// ==== rtl/mul_pipe.sv ====
/* keeps only the low 32 bits of the product, MUL_STAGES cycles to the output
   one multiply may enter every cycle */
module mul_pipe
	import core_pkg::*;
#(
	parameter int MUL_STAGES = 4
)
(
	input  logic      clk,
	input  logic      rst,
	input  logic      i_valid,
	input  data_t     i_op_a,
	input  data_t     i_op_b,
	input  reg_addr_t i_dest,
	output logic      o_valid,
	output data_t     o_result,
	output reg_addr_t o_dest
);
	logic [MUL_STAGES-1:0] stage_valid;
	data_t                 stage_res  [MUL_STAGES];
	reg_addr_t             stage_dest [MUL_STAGES];
	data_t                 product;

	assign product = i_op_a * i_op_b;    // truncated to the word

	always_ff @(posedge clk)
	begin
		if (!rst)
			stage_valid <= '0;
		else
			stage_valid <= {stage_valid[MUL_STAGES-2:0], i_valid};
	end

	always_ff @(posedge clk)
	begin
		stage_res[0]  <= product;
		stage_dest[0] <= i_dest;
		for (int i = 1; i < MUL_STAGES; i++)
		begin
			stage_res[i]  <= stage_res[i-1];
			stage_dest[i] <= stage_dest[i-1];
		end
	end

	assign o_valid  = stage_valid[MUL_STAGES-1];
	assign o_result = stage_res[MUL_STAGES-1];
	assign o_dest   = stage_dest[MUL_STAGES-1];

endmodule

// ==== rtl/register_file.sv ====
/* registers come out of reset holding their own index, r0 included
   a read of the register being written returns the new data in the same cycle */
module register_file
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  reg_addr_t i_rd_addr_a,
	input  reg_addr_t i_rd_addr_b,
	output data_t     o_rd_data_a,
	output data_t     o_rd_data_b,
	input  logic      i_wr_en,
	input  reg_addr_t i_wr_addr,
	input  data_t     i_wr_data
);
	data_t regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= DATA_W'(i);    // r holds r
		end
		else if (i_wr_en)
		begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// write bypass
	assign o_rd_data_a = (i_wr_en && i_wr_addr == i_rd_addr_a) ? i_wr_data
		: regs[i_rd_addr_a];
	assign o_rd_data_b = (i_wr_en && i_wr_addr == i_rd_addr_b) ? i_wr_data
		: regs[i_rd_addr_b];

endmodule

// ==== rtl/writeback.sv ====
/* one register write per cycle; issue guarantees that the two pipes
   never finish in the same cycle */
module writeback
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      i_alu_valid,
	input  data_t     i_alu_result,
	input  reg_addr_t i_alu_dest,
	input  logic      i_mul_valid,
	input  data_t     i_mul_result,
	input  reg_addr_t i_mul_dest,
	output logic      o_wb_en,
	output reg_addr_t o_wb_addr,
	output data_t     o_wb_data
);

	always_ff @(posedge clk)
	begin
		if (!rst)
			o_wb_en <= 1'b0;
		else
			o_wb_en <= i_alu_valid | i_mul_valid;
	end

	always_ff @(posedge clk)
	begin
		if (i_mul_valid)
		begin
			o_wb_addr <= i_mul_dest;
			o_wb_data <= i_mul_result;
		end
		else
		begin
			o_wb_addr <= i_alu_dest;
			o_wb_data <= i_alu_result;
		end
	end

	// both valid means the collision stall in issue let one through
	a_no_collision: assert property (@(posedge clk) disable iff (!rst)
		!(i_alu_valid && i_mul_valid));

endmodule

// ==== sim.f ====
rtl/core_pkg.sv
rtl/register_file.sv
rtl/issue_stage.sv
rtl/alu_pipe.sv
rtl/mul_pipe.sv
rtl/writeback.sv
rtl/exec_core.sv
verification/clock_gen.sv
verification/exec_core_tb.sv

// ==== verification/clock_gen.sv ====
/* free-running clock, reset held low for RESET_CYCLES rising edges
   reset is released 10 time units after an edge, in step with the stimulus */
module clock_gen
#(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 4
)
(
	output logic o_clk,
	output logic o_rst
);

	initial
	begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	initial
	begin
		o_rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#10 o_rst = 1'b1;
	end

endmodule

// ==== verification/exec_core_tb.sv ====
/* directed tests of the execution core against a register model
   inputs change 10 units after the rising edge, writebacks are sampled 1 unit after it */
module exec_core_tb
	import core_pkg::*;
();
	localparam int MUL_STAGES = 4;
	localparam int PERIOD     = 100;
	localparam int NUM_INSTR  = 31;    // instructions sent over all tests

	logic        clk;
	logic        rst;
	instr_u      i_inst;
	logic        i_inst_valid;
	logic        o_stall;
	logic        o_wb_en;
	reg_addr_t   o_wb_addr;
	data_t       o_wb_data;

	data_t       model [NUM_REGS];
	data_t       exp_data [int];    // keyed by the cycle of the expected write
	reg_addr_t   exp_dest [int];
	int          cyc       = 0;
	int          err_value = 0;
	int          err_other = 0;
	logic [31:0] lfsr      = 32'h3fe17cdd;

	clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(4)) u_clk (.o_clk(clk), .o_rst(rst));

	exec_core #(.MUL_STAGES(MUL_STAGES)) DUT (
		.clk          (clk),
		.rst          (rst),
		.i_inst       (i_inst),
		.i_inst_valid (i_inst_valid),
		.o_stall      (o_stall),
		.o_wb_en      (o_wb_en),
		.o_wb_addr    (o_wb_addr),
		.o_wb_data    (o_wb_data)
	);

	function automatic logic [15:0] rand_imm();
		logic [15:0] v;
		logic        b;
		for (int i = 0; i < 16; i++)
		begin
			b    = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 32'h80200003;    // galois taps
			v[i] = b;
		end
		return v;
	endfunction

	function automatic instr_u r_word(input logic [5:0] funct, input reg_addr_t rd,
		input reg_addr_t rs, input reg_addr_t rt);
		instr_u w;
		w.r = '{OP_RTYPE, rs, rt, rd, 5'd0, funct};
		return w;
	endfunction

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			err_value++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
		begin
			err_value++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
		begin
			err_value++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// hold the instruction through any stall, then book its writeback cycle
	task automatic send(input instr_u inst, input logic wr, input logic is_mul,
		input reg_addr_t dest, input data_t res, input int stalls);
		int n;
		int slot;
		n            = 0;
		i_inst       = inst;
		i_inst_valid = 1'b1;
		@(negedge clk);
		check_flag("o_stall", o_stall, n < stalls);
		while (o_stall && n < 8)
		begin
			n++;
			@(negedge clk);
			check_flag("o_stall", o_stall, n < stalls);
		end
		if (o_stall)
		begin
			err_other++;
			$display("o_stall stayed high at %0t, the instruction was never accepted", $time);
		end
		slot = cyc + 1 + (is_mul ? MUL_STAGES + 1 : 2);    // acceptance edge plus latency
		if (wr)
		begin
			exp_data[slot] = res;
			exp_dest[slot] = dest;
		end
		@(posedge clk);
		#10;
	endtask

	task automatic idle(input int n);
		i_inst_valid = 1'b0;
		repeat (n)
		begin
			@(posedge clk);
			#10;
		end
	endtask

	task automatic do_addi(input reg_addr_t rt, input reg_addr_t rs, input logic [15:0] imm);
		instr_u w;
		w.i = '{OP_ADDI, rs, rt, imm};
		send(w, 1'b1, 1'b0, rt, model[rs] + {16'd0, imm}, 0);
	endtask

	task automatic do_alu(input logic [5:0] funct, input reg_addr_t rd, input reg_addr_t rs,
		input reg_addr_t rt, input int stalls);
		data_t a;
		data_t b;
		data_t res;
		a = model[rs];
		b = model[rt];
		case (funct)
			FN_ADD:  res = a + b;
			FN_SUB:  res = a - b;
			FN_AND:  res = a & b;
			default: res = (a < b) ? 32'd1 : 32'd0;    // unsigned slt
		endcase
		send(r_word(funct, rd, rs, rt), 1'b1, 1'b0, rd, res, stalls);
	endtask

	task automatic do_mul(input reg_addr_t rd, input reg_addr_t rs, input reg_addr_t rt);
		send(r_word(FN_MUL, rd, rs, rt), 1'b1, 1'b1, rd, model[rs] * model[rt], 0);
	endtask

	task automatic test_reset();
		@(negedge clk);
		check_flag("o_wb_en", o_wb_en, 1'b0);
		@(posedge clk);
		#10;
		do_alu(FN_ADD, 5'd20, 5'd7, 5'd0, 0);    // r7 + r0 gives 7
		do_alu(FN_ADD, 5'd21, 5'd31, 5'd0, 0);
		idle(MUL_STAGES + 4);
	endtask

	task automatic test_alu();
		for (int r = 1; r <= 4; r++)
			do_addi(reg_addr_t'(r), 5'd0, rand_imm());
		idle(MUL_STAGES + 4);
		do_alu(FN_ADD, 5'd5, 5'd1, 5'd2, 0);
		do_alu(FN_SUB, 5'd6, 5'd0, 5'd1, 0);    // wraps to a value with bit 31 set
		do_alu(FN_AND, 5'd7, 5'd3, 5'd4, 0);
		do_alu(FN_SLT, 5'd8, 5'd1, 5'd2, 0);
		do_alu(FN_SLT, 5'd9, 5'd2, 5'd1, 0);
		do_addi(5'd10, 5'd3, rand_imm());
		idle(MUL_STAGES + 4);
	endtask

	// one per cycle so that any gap shows in the monitor
	task automatic test_alu_stream();
		do_addi(5'd23, 5'd1, 16'd5);
		do_alu(FN_SUB, 5'd24, 5'd2, 5'd3, 0);
		do_alu(FN_AND, 5'd25, 5'd1, 5'd4, 0);
		do_addi(5'd26, 5'd4, rand_imm());
		do_alu(FN_SLT, 5'd27, 5'd6, 5'd4, 0);    // large r6 is not below r4
		do_alu(FN_ADD, 5'd28, 5'd2, 5'd2, 0);
		idle(MUL_STAGES + 4);
	endtask

	task automatic test_mul();
		do_mul(5'd11, 5'd1, 5'd2);
		do_mul(5'd12, 5'd3, 5'd4);
		do_mul(5'd13, 5'd1, 5'd3);
		idle(MUL_STAGES + 4);
		do_mul(5'd14, 5'd11, 5'd12);    // product of products wraps
		idle(MUL_STAGES + 4);
	endtask

	task automatic test_collision();
		do_mul(5'd15, 5'd1, 5'd2);
		idle(MUL_STAGES - 2);
		do_alu(FN_ADD, 5'd16, 5'd3, 5'd4, 1);    // stalled for one cycle
		idle(MUL_STAGES + 4);
		do_mul(5'd19, 5'd1, 5'd3);
		idle(MUL_STAGES - 2);
		do_mul(5'd22, 5'd2, 5'd4);    // multiplies never stall
		idle(MUL_STAGES - 2);
		send(r_word(6'd32, 5'd29, 5'd1, 5'd2), 1'b0, 1'b0, 5'd0, '0, 0);
		idle(MUL_STAGES + 4);
	endtask

	task automatic test_nop_bypass();
		instr_u w;
		w = r_word(FN_ADD, 5'd1, 5'd2, 5'd3);
		w.r.opcode = 6'd7;    // unknown opcode
		send(w, 1'b0, 1'b0, 5'd0, '0, 0);
		send(r_word(6'd3, 5'd2, 5'd3, 5'd4), 1'b0, 1'b0, 5'd0, '0, 0);
		do_addi(5'd17, 5'd0, rand_imm());
		idle(2);    // now in the cycle r17 is on the write port
		do_alu(FN_ADD, 5'd18, 5'd17, 5'd1, 0);
		idle(MUL_STAGES + 4);
	endtask

	// writeback monitor checks every cycle after reset
	initial
	begin
		forever
		begin
			@(posedge clk);
			cyc++;
			#1;
			if (rst)
			begin
				if (exp_data.exists(cyc))
				begin
					check_flag("o_wb_en", o_wb_en, 1'b1);
					if (o_wb_en)
					begin
						check_addr("o_wb_addr", o_wb_addr, exp_dest[cyc]);
						check_data("o_wb_data", o_wb_data, exp_data[cyc]);
					end
					model[exp_dest[cyc]] = exp_data[cyc];
					exp_data.delete(cyc);
					exp_dest.delete(cyc);
				end
				else
					check_flag("o_wb_en", o_wb_en, 1'b0);
			end
		end
	end

	initial
	begin
		#(PERIOD * (NUM_INSTR * (MUL_STAGES + 4) + 50));
		$display("watchdog expired at %0t, the tests did not finish", $time);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		i_inst       = '0;
		i_inst_valid = 1'b0;
		for (int r = 0; r < NUM_REGS; r++)
			model[r] = data_t'(r);
		@(posedge rst);
		test_reset();
		test_alu();
		test_alu_stream();
		test_mul();
		test_collision();
		test_nop_bypass();
		if (exp_data.num() != 0)
		begin
			err_other++;
			$display("%0d expected writebacks never appeared", exp_data.num());
		end
		$display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
		if (err_value + err_other == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
